// File: hdl/mem_pkg.sv
// access-side types and size encoding for the load/store path
package mem_pkg;

    // byte address as seen by the CPU
    typedef logic [31:0] addr_t;

    // one data word
    typedef logic [31:0] word_t;

    // byte enables, bit n set means byte n is written
    typedef logic [3:0] bmask_t;

    // access control: [1:0] size, [2] zero extension on loads
    typedef logic [2:0] ctrl_t;

    // size field values
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // position of the zero-extend select inside ctrl_t
    localparam int CTRL_ZEXT = 2;

endpackage

// File: hdl/dram_pkg.sv
// word controller constants: array depth, init length, busy lengths, refresh interval
package dram_pkg;

    localparam int MEM_WORDS = 256;                // 1 KiB of storage
    localparam int WADDR_W   = $clog2(MEM_WORDS);

    // word index into the array
    typedef logic [WADDR_W-1:0] waddr_t;

    localparam int INIT_CYCLES  = 64;  // power-up period
    localparam int ACCESS_BUSY  = 3;   // read or write
    localparam int REFRESH_BUSY = 5;

    // counter widths sized from the lengths above
    localparam int INIT_CNT_W = $clog2(INIT_CYCLES + 1);
    localparam int BUSY_CNT_W = $clog2(REFRESH_BUSY + 1);

    // refresh interval in idle cycles
    typedef logic [15:0] rint_t;

    localparam rint_t REFRESH_DEFAULT = 16'd200;

endpackage

// File: hdl/refresh_sched.sv
// refresh request generator with interval register and idle-cycle counter
`timescale 1ns/100ps

module refresh_sched
    import dram_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_cfg_we,
    input  rint_t i_cfg_interval,
    input  logic  i_init_done,
    input  logic  i_mc_busy,
    input  logic  i_refresh_ack,
    output logic  o_refresh_req
);

    rint_t r_interval;
    rint_t idle_cnt;
    rint_t idle_next;
    logic  count_en;

    // only idle, initialised cycles count towards the next refresh
    assign count_en  = i_init_done && !i_mc_busy && !o_refresh_req;
    assign idle_next = idle_cnt + 1'b1;

    // interval register
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_interval <= REFRESH_DEFAULT;
        end else if (i_cfg_we) begin
            r_interval <= i_cfg_interval;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            idle_cnt      <= '0;
            o_refresh_req <= 1'b0;
        end else if (i_refresh_ack) begin
            idle_cnt      <= '0;        // restart after the refresh is issued
            o_refresh_req <= 1'b0;
        end else if (count_en) begin
            idle_cnt <= idle_next;
            // >= so that a smaller interval written mid-count still fires
            if (idle_next >= r_interval) begin
                o_refresh_req <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/word_mem_ctrl.sv
// masked word memory controller with power-up period, busy timing and refresh
`timescale 1ns/100ps

module word_mem_ctrl
    import mem_pkg::*, dram_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_rd,
    input  logic   i_wr,
    input  logic   i_refresh,
    input  waddr_t i_waddr,
    input  word_t  i_wdata,
    input  bmask_t i_wmask,
    output word_t  o_rdata,
    output logic   o_busy,
    output logic   o_init_done
);

    logic [INIT_CNT_W-1:0] init_cnt;
    logic [BUSY_CNT_W-1:0] busy_cnt;
    logic                  r_op_rd;      // operation in flight is a read
    logic                  r_op_wr;      // operation in flight is a write
    logic                  accept;
    logic                  op_last;

    waddr_t r_waddr;
    word_t  r_wdata;
    bmask_t r_wmask;

    word_t mem [MEM_WORDS];

    assign o_busy  = !o_init_done || (busy_cnt != '0);
    assign accept  = !o_busy && (i_rd || i_wr || i_refresh);
    assign op_last = (busy_cnt == BUSY_CNT_W'(1));

    // init period, then one operation at a time
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            init_cnt    <= '0;
            o_init_done <= 1'b0;
            busy_cnt    <= '0;
            r_op_rd     <= 1'b0;
            r_op_wr     <= 1'b0;
        end else if (!o_init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == INIT_CNT_W'(INIT_CYCLES - 1)) begin
                o_init_done <= 1'b1;
            end
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end else if (i_refresh) begin
            busy_cnt <= BUSY_CNT_W'(REFRESH_BUSY);
            r_op_rd  <= 1'b0;
            r_op_wr  <= 1'b0;
        end else if (i_rd) begin
            busy_cnt <= BUSY_CNT_W'(ACCESS_BUSY);
            r_op_rd  <= 1'b1;
            r_op_wr  <= 1'b0;
        end else if (i_wr) begin
            busy_cnt <= BUSY_CNT_W'(ACCESS_BUSY);
            r_op_rd  <= 1'b0;
            r_op_wr  <= 1'b1;
        end
    end

    // command payload held for the whole busy period
    always_ff @(posedge clk) begin
        if (accept) begin
            r_waddr <= i_waddr;
            r_wdata <= i_wdata;
            r_wmask <= i_wmask;
        end
    end

    // array access happens on the last busy cycle
    // so read data shows up exactly as busy drops
    always_ff @(posedge clk) begin
        if (op_last && r_op_rd) begin
            o_rdata <= mem[r_waddr];
        end
        if (op_last && r_op_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (r_wmask[b]) begin
                    mem[r_waddr][b*8 +: 8] <= r_wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/unaligned_lsu.sv
// load/store adapter: unaligned access splitting, store alignment and masking, load extension
`timescale 1ns/100ps

module unaligned_lsu
    import mem_pkg::*, dram_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_rd_en,
    input  logic   i_wr_en,
    input  addr_t  i_addr,
    input  word_t  i_wdata,
    input  ctrl_t  i_ctrl,
    input  word_t  i_mc_rdata,
    input  logic   i_mc_busy,
    input  logic   i_refresh_req,
    output word_t  o_rdata,
    output logic   o_busy,
    output logic   o_mc_rd,
    output logic   o_mc_wr,
    output logic   o_mc_refresh,
    output logic   o_refresh_ack,
    output waddr_t o_mc_waddr,
    output word_t  o_mc_wdata,
    output bmask_t o_mc_wmask
);

    typedef enum logic [3:0] {
        IDLE,
        RD_ISSUE,
        RD_WAIT,
        RD2_ISSUE,
        RD2_WAIT,
        WR_ISSUE,
        WR_WAIT,
        WR2_ISSUE,
        WR2_WAIT,
        REF_ISSUE,
        REF_WAIT,
        DONE
    } state_t;

    state_t state;
    logic   r_seen_busy;    // controller went busy since the strobe
    logic   r_pending;      // CPU access accepted together with a refresh
    logic   r_is_load;

    waddr_t     r_waddr;
    logic [1:0] r_off;
    ctrl_t      r_ctrl;
    word_t      r_wdata;
    word_t      r_lo;
    word_t      r_hi;

    logic        accept;
    logic        in_wait;
    logic        op_done;
    logic        crosses;
    logic        second;
    bmask_t      size_mask;
    logic [7:0]  wide_mask;
    logic [63:0] wide_data;
    logic [63:0] rd_pair;
    word_t       ld_raw;
    word_t       ld_data;

    assign accept  = (state == IDLE) && !i_mc_busy && (i_rd_en || i_wr_en);
    assign in_wait = state inside {RD_WAIT, RD2_WAIT, WR_WAIT, WR2_WAIT, REF_WAIT};
    assign op_done = in_wait && r_seen_busy && !i_mc_busy;

    always_comb begin
        case (r_ctrl[1:0])
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    // little-endian placement over two adjacent words
    assign wide_mask = {4'b0000, size_mask} << r_off;
    assign wide_data = {32'd0, r_wdata} << {r_off, 3'b000};
    assign crosses   = |wide_mask[7:4];   // half at 3, word at 1..3
    assign second    = (state == RD2_ISSUE) || (state == WR2_ISSUE);

    // load rebuild from the low and high word
    assign rd_pair = {r_hi, r_lo} >> {r_off, 3'b000};
    assign ld_raw  = rd_pair[31:0];

    always_comb begin
        case (r_ctrl[1:0])
            SIZE_BYTE: ld_data = r_ctrl[CTRL_ZEXT] ? {24'd0, ld_raw[7:0]}
                                                   : {{24{ld_raw[7]}}, ld_raw[7:0]};
            SIZE_HALF: ld_data = r_ctrl[CTRL_ZEXT] ? {16'd0, ld_raw[15:0]}
                                                   : {{16{ld_raw[15]}}, ld_raw[15:0]};
            default:   ld_data = ld_raw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_seen_busy <= 1'b0;
        end else if (op_done) begin
            r_seen_busy <= 1'b0;
        end else if (in_wait && i_mc_busy) begin
            r_seen_busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            r_pending <= 1'b0;
            r_is_load <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!i_mc_busy) begin
                        r_pending <= i_rd_en || i_wr_en;
                        r_is_load <= i_rd_en;
                        if (i_refresh_req) begin
                            state <= REF_ISSUE;     // refresh goes first
                        end else if (i_rd_en) begin
                            state <= RD_ISSUE;
                        end else if (i_wr_en) begin
                            state <= WR_ISSUE;
                        end
                    end
                end
                RD_ISSUE:  state <= RD_WAIT;
                RD_WAIT:   if (op_done) state <= crosses ? RD2_ISSUE : DONE;
                RD2_ISSUE: state <= RD2_WAIT;
                RD2_WAIT:  if (op_done) state <= DONE;
                WR_ISSUE:  state <= WR_WAIT;
                WR_WAIT:   if (op_done) state <= crosses ? WR2_ISSUE : DONE;
                WR2_ISSUE: state <= WR2_WAIT;
                WR2_WAIT:  if (op_done) state <= DONE;
                REF_ISSUE: state <= REF_WAIT;
                REF_WAIT: begin
                    if (op_done) begin
                        if (!r_pending) begin
                            state <= DONE;
                        end else begin
                            state <= r_is_load ? RD_ISSUE : WR_ISSUE;
                        end
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request capture and returned data
    always_ff @(posedge clk) begin
        if (accept) begin
            r_waddr <= i_addr[WADDR_W+1:2];
            r_off   <= i_addr[1:0];
            r_ctrl  <= i_ctrl;
            r_wdata <= i_wdata;
        end
        if (state == RD_WAIT && op_done) begin
            r_lo <= i_mc_rdata;
        end
        if (state == RD2_WAIT && op_done) begin
            r_hi <= i_mc_rdata;
        end
        if (state == DONE && r_pending && r_is_load) begin
            o_rdata <= ld_data;
        end
    end

    assign o_busy        = (state != IDLE) || i_mc_busy;
    assign o_mc_rd       = (state == RD_ISSUE) || (state == RD2_ISSUE);
    assign o_mc_wr       = (state == WR_ISSUE) || (state == WR2_ISSUE);
    assign o_mc_refresh  = (state == REF_ISSUE);
    assign o_refresh_ack = (state == REF_ISSUE);

    // second word wraps around the array
    assign o_mc_waddr = second ? waddr_t'(r_waddr + 1'b1) : r_waddr;
    assign o_mc_wdata = second ? wide_data[63:32] : wide_data[31:0];
    assign o_mc_wmask = second ? wide_mask[7:4] : wide_mask[3:0];

endmodule

// File: hdl/dram_subsys.sv
// memory subsystem top: load/store adapter, refresh scheduler and word controller
`timescale 1ns/100ps

module dram_subsys
    import mem_pkg::*, dram_pkg::*;
(
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_rd_en,
    input  logic  i_wr_en,
    input  addr_t i_addr,
    input  word_t i_wdata,
    input  ctrl_t i_ctrl,
    input  logic  i_cfg_we,
    input  rint_t i_cfg_interval,
    output word_t o_rdata,
    output logic  o_busy,
    output logic  o_init_done
);

    logic   mc_rd;
    logic   mc_wr;
    logic   mc_refresh;
    waddr_t mc_waddr;
    word_t  mc_wdata;
    bmask_t mc_wmask;
    word_t  mc_rdata;
    logic   mc_busy;
    logic   refresh_req;
    logic   refresh_ack;

    unaligned_lsu i_unaligned_lsu (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_rd_en       (i_rd_en),
        .i_wr_en       (i_wr_en),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .i_ctrl        (i_ctrl),
        .i_mc_rdata    (mc_rdata),
        .i_mc_busy     (mc_busy),
        .i_refresh_req (refresh_req),
        .o_rdata       (o_rdata),
        .o_busy        (o_busy),
        .o_mc_rd       (mc_rd),
        .o_mc_wr       (mc_wr),
        .o_mc_refresh  (mc_refresh),
        .o_refresh_ack (refresh_ack),
        .o_mc_waddr    (mc_waddr),
        .o_mc_wdata    (mc_wdata),
        .o_mc_wmask    (mc_wmask)
    );

    refresh_sched i_refresh_sched (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_cfg_we       (i_cfg_we),
        .i_cfg_interval (i_cfg_interval),
        .i_init_done    (o_init_done),
        .i_mc_busy      (mc_busy),
        .i_refresh_ack  (refresh_ack),
        .o_refresh_req  (refresh_req)
    );

    word_mem_ctrl i_word_mem_ctrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rd        (mc_rd),
        .i_wr        (mc_wr),
        .i_refresh   (mc_refresh),
        .i_waddr     (mc_waddr),
        .i_wdata     (mc_wdata),
        .i_wmask     (mc_wmask),
        .o_rdata     (mc_rdata),
        .o_busy      (mc_busy),
        .o_init_done (o_init_done)
    );

endmodule

// File: testbench/tb_clkgen.sv
// clock and active-low reset source for the testbench
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD = 2;   // 4 ns clock
    localparam int RST_CYCLES  = 4;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// File: testbench/tb_dram_subsys.sv
// trace-driven testbench for the memory subsystem with init check, watchdog and result line
`timescale 1ns/100ps

module tb_dram_subsys
    import mem_pkg::*, dram_pkg::*;
();

    localparam int CLK_PERIOD  = 4;    // ns
    localparam int LINE_BUDGET = 40;   // cycles allowed per trace line

    logic  clk;
    logic  rst_n;
    logic  rd_en;
    logic  wr_en;
    addr_t addr;
    word_t wdata;
    ctrl_t ctrl;
    logic  cfg_we;
    rint_t cfg_interval;
    word_t rdata;
    logic  busy;
    logic  init_done;

    // one entry per trace operation
    logic [7:0] q_op[$];
    ctrl_t      q_ctrl[$];
    addr_t      q_addr[$];
    word_t      q_data[$];
    word_t      q_exp[$];
    int         q_line[$];

    int   errors = 0;
    int   checks = 0;
    logic loaded = 1'b0;

    tb_clkgen i_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    dram_subsys i_dram_subsys (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_rd_en        (rd_en),
        .i_wr_en        (wr_en),
        .i_addr         (addr),
        .i_wdata        (wdata),
        .i_ctrl         (ctrl),
        .i_cfg_we       (cfg_we),
        .i_cfg_interval (cfg_interval),
        .o_rdata        (rdata),
        .o_busy         (busy),
        .o_init_done    (init_done)
    );

    // every drive and sample happens 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        while (busy) begin
            step();
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          cnt;
        int          lnum;
        string       line;
        logic [7:0]  op;
        logic [31:0] t_ctrl;
        logic [31:0] t_addr;
        logic [31:0] t_data;
        logic [31:0] t_exp;
        lnum = 0;
        fd = $fopen("testbench/dram_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open the trace file testbench/dram_trace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            lnum++;
            cnt = $sscanf(line, "%c %h %h %h %h", op, t_ctrl, t_addr, t_data, t_exp);
            if (cnt == 5) begin   // comment lines stop short
                q_op.push_back(op);
                q_ctrl.push_back(ctrl_t'(t_ctrl));
                q_addr.push_back(t_addr);
                q_data.push_back(t_data);
                q_exp.push_back(t_exp);
                q_line.push_back(lnum);
            end
        end
        $fclose(fd);
        if (q_op.size() == 0) begin
            $display("error: the trace file holds no operations");
            errors++;
        end
    endtask

    task automatic check_init();
        int cycles;
        cycles = 0;
        while (!init_done) begin
            step();
            cycles++;
            if (!init_done && !busy) begin
                $display("error: o_busy dropped during the init period at cycle %0d", cycles);
                errors++;
            end
        end
        checks++;
        if (cycles != INIT_CYCLES) begin
            $display("mismatch init_length: expected %0d, actual %0d", INIT_CYCLES, cycles);
            errors++;
        end
        if (busy) begin
            $display("error: o_busy is still high after o_init_done rose");
            errors++;
        end
    endtask

    task automatic run_line(input int idx);
        string name;
        name = $sformatf("line %0d %c", q_line[idx], q_op[idx]);
        case (q_op[idx])
            "C": begin
                cfg_interval = rint_t'(q_data[idx]);
                cfg_we       = 1'b1;
                step();
                cfg_we = 1'b0;
            end
            "W", "R": begin
                wait_idle();
                addr  = q_addr[idx];
                wdata = q_data[idx];
                ctrl  = q_ctrl[idx];
                rd_en = (q_op[idx] == "R");
                wr_en = (q_op[idx] == "W");
                step();
                rd_en = 1'b0;
                wr_en = 1'b0;
                if (!busy) begin
                    $display("error: %s was not accepted, o_busy stayed low", name);
                    errors++;
                end
                wait_idle();   // o_busy falling ends the access
                if (q_op[idx] == "R") begin
                    checks++;
                    if (rdata !== q_exp[idx]) begin
                        $display("mismatch %s: expected %h, actual %h", name, q_exp[idx], rdata);
                        errors++;
                    end
                end
            end
            default: begin
                $display("error: %s has an unknown operation", name);
                errors++;
            end
        endcase
    endtask

    initial begin
        rd_en        = 1'b0;
        wr_en        = 1'b0;
        addr         = '0;
        wdata        = '0;
        ctrl         = '0;
        cfg_we       = 1'b0;
        cfg_interval = '0;
        load_trace();
        loaded = 1'b1;
        wait (rst_n === 1'b1);
        check_init();
        for (int i = 0; i < q_op.size(); i++) begin
            run_line(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // budget covers init plus a worst case refresh and split access per line
    initial begin
        longint limit;
        wait (loaded === 1'b1);
        limit = (longint'(q_op.size()) * LINE_BUDGET + INIT_CYCLES + 100) * CLK_PERIOD;
        #(limit);
        $display("error: watchdog expired after %0d ns before the trace completed", limit);
        $display("test failed");
        $finish;
    end

endmodule

// File: testbench/dram_trace.txt
# op ctrl addr data expected (hex); ctrl [1:0] size 0 byte 1 half 2 word, [2] zero extend
# op C writes data to the refresh interval, W stores data, R loads and checks expected
W 2 00000000 11223344 00000000
W 2 00000004 55667788 00000000
W 2 00000008 99aabbcc 00000000
W 2 0000000c ddeeff00 00000000
W 2 00000010 13579bdf 00000000
W 1 00000000 0000beef 00000000
W 0 00000002 000000a5 00000000
R 2 00000000 00000000 11a5beef
W 1 00000003 0000cafe 00000000
W 2 00000006 0a0b0c0d 00000000
W 2 0000000b 01020304 00000000
W 2 0000000d 5566aa77 00000000
R 2 00000000 00000000 fea5beef
R 2 00000004 00000000 0c0d77ca
R 2 00000008 00000000 04aa0a0b
R 2 0000000c 00000000 66aa7703
R 2 00000010 00000000 13579b55
R 2 00000003 00000000 0d77cafe
R 1 00000003 00000000 ffffcafe
R 5 00000003 00000000 0000cafe
R 0 00000001 00000000 ffffffbe
R 4 00000001 00000000 000000be
R 2 0000000a 00000000 770304aa
C 0 00000000 00000004 00000000
W 2 00000014 2468ace0 00000000
R 1 00000013 00000000 ffffe013
W 0 00000015 000000f1 00000000
R 2 00000014 00000000 2468f1e0
R 2 00000012 00000000 f1e01357

// File: tb.f
hdl/mem_pkg.sv
hdl/dram_pkg.sv
hdl/refresh_sched.sv
hdl/word_mem_ctrl.sv
hdl/unaligned_lsu.sv
hdl/dram_subsys.sv
testbench/tb_clkgen.sv
testbench/tb_dram_subsys.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_dram_subsys -f tb.f \
    && ./obj_dir/Vtb_dram_subsys > sim.log 2>&1 \
    || echo "test failed: build or simulation error" >> sim.log
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
